// File: conv1x1_pkg.sv
package conv1x1_pkg;

  ////////////////////////////////////////////////////////////
  // Number format
  ////////////////////////////////////////////////////////////

  // Signed fixed point, 8 fraction bits
  localparam int DATA_WIDTH = 16;
  localparam int FRAC_BITS  = 8;

  // Headroom for the sum over input channels
  localparam int ACC_WIDTH  = 40;

  typedef logic signed [DATA_WIDTH-1:0] data_t;
  typedef logic signed [ACC_WIDTH-1:0]  acc_t;

  // Clamp limits of data_t, held at accumulator width
  localparam acc_t DATA_MAX = acc_t'(2 ** (DATA_WIDTH - 1) - 1);
  localparam acc_t DATA_MIN = -acc_t'(2 ** (DATA_WIDTH - 1));

  ////////////////////////////////////////////////////////////
  // Stream beats
  ////////////////////////////////////////////////////////////

  // One replayed channel value
  typedef struct packed {
    data_t data;
    logic  first;
    logic  last;
  } pxl_beat_t;

  // One product, flags follow the beat
  typedef struct packed {
    acc_t prod;
    logic first;
    logic last;
  } prod_beat_t;

  // Drop the fraction bits, then clamp into data_t
  function automatic data_t round_sat(input acc_t value);
    acc_t shifted;
    shifted = value >>> FRAC_BITS;
    if (shifted > DATA_MAX) begin
      return data_t'(DATA_MAX);
    end
    if (shifted < DATA_MIN) begin
      return data_t'(DATA_MIN);
    end
    return data_t'(shifted);
  endfunction

endpackage

// File: conv_loop_buffer.sv
`timescale 1ns/1ns

module conv_loop_buffer #(
  parameter int CHANNEL_NUM_IN  = 4,
  parameter int CHANNEL_NUM_OUT = 3
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   valid_in,
  input  conv1x1_pkg::data_t     pxl_in,
  output conv1x1_pkg::pxl_beat_t beat,
  output logic                   beat_valid
);

  localparam int IC_W = (CHANNEL_NUM_IN > 1) ? $clog2(CHANNEL_NUM_IN) : 1;
  localparam int OC_W = (CHANNEL_NUM_OUT > 1) ? $clog2(CHANNEL_NUM_OUT) : 1;
  localparam logic [IC_W-1:0] IC_LAST = IC_W'(CHANNEL_NUM_IN - 1);
  localparam logic [OC_W-1:0] OC_LAST = OC_W'(CHANNEL_NUM_OUT - 1);

  // Two banks, one filling while the other replays
  conv1x1_pkg::data_t bank [2][CHANNEL_NUM_IN];

  logic [IC_W-1:0] cap_cnt;
  logic            cap_bank;
  logic            cap_done;

  logic            rep_active;
  logic            rep_bank;
  logic [IC_W-1:0] rep_ic;
  logic [OC_W-1:0] rep_oc;
  logic            rep_end;

  ////////////////////////////////////////////////////////////
  // Capture side
  ////////////////////////////////////////////////////////////

  assign cap_done = valid_in && (cap_cnt == IC_LAST);

  always_ff @(posedge clk) begin
    if (valid_in) begin
      bank[cap_bank][cap_cnt] <= pxl_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cap_cnt  <= '0;
      cap_bank <= 1'b0;
    end else if (valid_in) begin
      if (cap_done) begin
        cap_cnt  <= '0;
        cap_bank <= ~cap_bank;
      end else begin
        cap_cnt <= cap_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Replay side
  ////////////////////////////////////////////////////////////

  assign rep_end = (rep_ic == IC_LAST) && (rep_oc == OC_LAST);

  // A fresh hand-off wins over the end of the previous replay
  always_ff @(posedge clk) begin
    if (reset) begin
      rep_active <= 1'b0;
      rep_bank   <= 1'b0;
      rep_ic     <= '0;
      rep_oc     <= '0;
    end else if (cap_done) begin
      rep_active <= 1'b1;
      rep_bank   <= cap_bank;
      rep_ic     <= '0;
      rep_oc     <= '0;
    end else if (rep_active) begin
      if (rep_end) begin
        rep_active <= 1'b0;
        rep_ic     <= '0;
        rep_oc     <= '0;
      end else if (rep_ic == IC_LAST) begin
        rep_ic <= '0;
        rep_oc <= rep_oc + 1'b1;
      end else begin
        rep_ic <= rep_ic + 1'b1;
      end
    end
  end

  // Inner loop over input channels marks first and last
  assign beat_valid = rep_active;
  assign beat.data  = bank[rep_bank][rep_ic];
  assign beat.first = (rep_ic == '0);
  assign beat.last  = (rep_ic == IC_LAST);

endmodule

// File: conv_weight_mult.sv
`timescale 1ns/1ns

module conv_weight_mult #(
  parameter int CHANNEL_NUM_IN  = 4,
  parameter int CHANNEL_NUM_OUT = 3
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    valid_weight_in,
  input  conv1x1_pkg::data_t      weight_in,
  input  conv1x1_pkg::pxl_beat_t  beat,
  input  logic                    beat_valid,
  output conv1x1_pkg::prod_beat_t prod,
  output logic                    prod_valid
);

  // One weight per input and output channel pair
  localparam int NUM_WEIGHTS = CHANNEL_NUM_IN * CHANNEL_NUM_OUT;
  localparam int PTR_W = (NUM_WEIGHTS > 1) ? $clog2(NUM_WEIGHTS) : 1;
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(NUM_WEIGHTS - 1);

  conv1x1_pkg::data_t wmem [NUM_WEIGHTS];

  logic [PTR_W-1:0] load_ptr;
  logic [PTR_W-1:0] read_ptr;

  ////////////////////////////////////////////////////////////
  // Weight load
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (valid_weight_in) begin
      wmem[load_ptr] <= weight_in;
    end
  end

  // Wraps so a new full set replaces the old one
  always_ff @(posedge clk) begin
    if (reset) begin
      load_ptr <= '0;
    end else if (valid_weight_in) begin
      if (load_ptr == PTR_LAST) begin
        load_ptr <= '0;
      end else begin
        load_ptr <= load_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Multiply
  ////////////////////////////////////////////////////////////

  // Replay order matches the output-channel-major weight order
  always_ff @(posedge clk) begin
    if (reset) begin
      read_ptr <= '0;
    end else if (beat_valid) begin
      if (read_ptr == PTR_LAST) begin
        read_ptr <= '0;
      end else begin
        read_ptr <= read_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_valid) begin
      prod.prod  <= conv1x1_pkg::acc_t'(beat.data) * conv1x1_pkg::acc_t'(wmem[read_ptr]);
      prod.first <= beat.first;
      prod.last  <= beat.last;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= beat_valid;
    end
  end

endmodule

// File: conv_channel_adder.sv
`timescale 1ns/1ns

module conv_channel_adder (
  input  logic                    clk,
  input  logic                    reset,
  input  conv1x1_pkg::prod_beat_t prod,
  input  logic                    prod_valid,
  output conv1x1_pkg::data_t      sum,
  output logic                    sum_valid
);

  ////////////////////////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////////////////////////

  conv1x1_pkg::acc_t acc;
  conv1x1_pkg::acc_t acc_next;

  // First product of an output channel restarts the sum
  always_comb begin
    if (prod.first) begin
      acc_next = prod.prod;
    end else begin
      acc_next = acc + prod.prod;
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      acc <= acc_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////

  // Final sum taken straight from acc_next, no extra cycle
  always_ff @(posedge clk) begin
    if (prod_valid && prod.last) begin
      sum <= conv1x1_pkg::round_sat(acc_next);
    end
  end

  // One pulse per output channel
  always_ff @(posedge clk) begin
    if (reset) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= prod_valid && prod.last;
    end
  end

endmodule

// File: conv_out_align.sv
`timescale 1ns/1ns

module conv_out_align #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic               clk,
  input  logic               reset,
  input  conv1x1_pkg::data_t din,
  input  logic               wr_en,
  output conv1x1_pkg::data_t pxl_out,
  output logic               valid_out
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);

  conv1x1_pkg::data_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             empty;
  logic             read_en;
  logic             do_wr;
  logic             do_rd;

  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);
  assign do_wr = wr_en && !full;
  assign do_rd = read_en && !empty;

  ////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
    if (do_rd) begin
      pxl_out <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy holds when both sides move together
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Drain control
  ////////////////////////////////////////////////////////////

  // Draining starts once the FIFO has filled and never stops
  always_ff @(posedge clk) begin
    if (reset) begin
      read_en   <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      if (full) begin
        read_en <= 1'b1;
      end
      valid_out <= do_rd;
    end
  end

endmodule

// File: conv1x1_top.sv
`timescale 1ns/1ns

module conv1x1_top #(
  parameter int CHANNEL_NUM_IN  = 4,
  parameter int CHANNEL_NUM_OUT = 3,
  parameter int FIFO_DEPTH      = 8
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               valid_in,
  input  conv1x1_pkg::data_t pxl_in,
  input  logic               valid_weight_in,
  input  conv1x1_pkg::data_t weight_in,
  output conv1x1_pkg::data_t pxl_out,
  output logic               valid_out
);

  ////////////////////////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////////////////////////

  conv1x1_pkg::pxl_beat_t  beat;
  logic                    beat_valid;
  conv1x1_pkg::prod_beat_t prod;
  logic                    prod_valid;
  conv1x1_pkg::data_t      sum;
  logic                    sum_valid;

  // Capture one pixel, replay it per output channel
  conv_loop_buffer #(
    .CHANNEL_NUM_IN  (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT (CHANNEL_NUM_OUT)
  ) conv_loop_buffer_inst (
    .clk        (clk),
    .reset      (reset),
    .valid_in   (valid_in),
    .pxl_in     (pxl_in),
    .beat       (beat),
    .beat_valid (beat_valid)
  );

  conv_weight_mult #(
    .CHANNEL_NUM_IN  (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT (CHANNEL_NUM_OUT)
  ) conv_weight_mult_inst (
    .clk             (clk),
    .reset           (reset),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .beat            (beat),
    .beat_valid      (beat_valid),
    .prod            (prod),
    .prod_valid      (prod_valid)
  );

  conv_channel_adder conv_channel_adder_inst (
    .clk        (clk),
    .reset      (reset),
    .prod       (prod),
    .prod_valid (prod_valid),
    .sum        (sum),
    .sum_valid  (sum_valid)
  );

  // Holds results until the first fill, then streams them out
  conv_out_align #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) conv_out_align_inst (
    .clk       (clk),
    .reset     (reset),
    .din       (sum),
    .wr_en     (sum_valid),
    .pxl_out   (pxl_out),
    .valid_out (valid_out)
  );

endmodule

// File: conv1x1_props.sv
`timescale 1ns/1ns

module conv1x1_props #(
  parameter int FIFO_DEPTH = 8
) (
  input logic clk,
  input logic reset,
  input logic wr_en,
  input logic full,
  input logic read_en,
  input logic valid_out
);

  int unsigned writes_seen;
  int unsigned outputs_seen;

  // Results accepted and results delivered since reset
  always_ff @(posedge clk) begin
    if (reset) begin
      writes_seen  <= 0;
      outputs_seen <= 0;
    end else begin
      if (wr_en && !full) begin
        writes_seen <= writes_seen + 1;
      end
      if (valid_out) begin
        outputs_seen <= outputs_seen + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Output FIFO rules
  ////////////////////////////////////////////////////////////

  // A result written into a full FIFO would be lost
  no_write_when_full: assert property (
    @(posedge clk) disable iff (reset) !(wr_en && full)
  ) else $error("Result written while the output FIFO is full");

  // The read enable may only latch once a full FIFO worth has arrived
  read_en_after_fill: assert property (
    @(posedge clk) disable iff (reset) read_en |-> writes_seen >= FIFO_DEPTH
  ) else $error("Read enable latched before the FIFO had filled");

  // Every output needs a result written earlier and not yet delivered
  valid_needs_result: assert property (
    @(posedge clk) disable iff (reset) valid_out |-> outputs_seen < writes_seen
  ) else $error("valid_out high with no written result left to deliver");

endmodule

bind conv_out_align conv1x1_props #(
  .FIFO_DEPTH (FIFO_DEPTH)
) conv1x1_props_inst (
  .clk       (clk),
  .reset     (reset),
  .wr_en     (wr_en),
  .full      (full),
  .read_en   (read_en),
  .valid_out (valid_out)
);

// File: tb_conv1x1.sv
`timescale 1ns/1ns

module tb_conv1x1;

  localparam int CHANNEL_NUM_IN  = 4;
  localparam int CHANNEL_NUM_OUT = 3;
  localparam int FIFO_DEPTH      = 8;
  localparam int CLK_PERIOD      = 20;
  localparam int NUM_TESTS       = 5;
  localparam int PIXEL_CYCLES    = CHANNEL_NUM_IN * CHANNEL_NUM_OUT;
  localparam int DRAIN_LIMIT     = 100;

  typedef enum logic [1:0] {W_RANDOM, W_DIAG, W_LARGE_POS, W_LARGE_NEG} weight_mode_t;

  typedef struct {
    string        name;
    int           pixels;
    weight_mode_t mode;
  } test_entry_t;

  // Name, pixel count, weight mode
  test_entry_t tests [NUM_TESTS] = '{
    '{"random_first", 5, W_RANDOM},
    '{"unit_diagonal", 4, W_DIAG},
    '{"large_positive", 6, W_LARGE_POS},
    '{"large_negative", 6, W_LARGE_NEG},
    '{"random_reload", 8, W_RANDOM}
  };

  logic               clk;
  logic               reset;
  logic               valid_in;
  conv1x1_pkg::data_t pxl_in;
  logic               valid_weight_in;
  conv1x1_pkg::data_t weight_in;
  conv1x1_pkg::data_t pxl_out;
  logic               valid_out;

  int unsigned        lcg_state = 32'h42ee876d;
  conv1x1_pkg::data_t weights [PIXEL_CYCLES];
  conv1x1_pkg::data_t expected_q [$];
  conv1x1_pkg::data_t expected_val;
  string              current_name = "reset";
  int                 results_seen = 0;
  logic               drain_started = 1'b0;
  int                 check_count = 0;
  int                 mismatch_count = 0;
  int                 other_errors = 0;

  conv1x1_top #(
    .CHANNEL_NUM_IN  (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT (CHANNEL_NUM_OUT),
    .FIFO_DEPTH      (FIFO_DEPTH)
  ) conv1x1_top_inst (
    .clk             (clk),
    .reset           (reset),
    .valid_in        (valid_in),
    .pxl_in          (pxl_in),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .pxl_out         (pxl_out),
    .valid_out       (valid_out)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Weight index is oc * CHANNEL_NUM_IN + ic
  function automatic conv1x1_pkg::data_t pick_weight(input weight_mode_t mode, input int index);
    int unsigned r;
    case (mode)
      W_RANDOM: begin
        // Roughly +-2.0, keeps most sums in range
        r = next_random();
        return conv1x1_pkg::data_t'($signed(r[25:16]));
      end
      W_DIAG: begin
        if (index / CHANNEL_NUM_IN == index % CHANNEL_NUM_IN) begin
          return conv1x1_pkg::data_t'(1 << conv1x1_pkg::FRAC_BITS);
        end
        return '0;
      end
      W_LARGE_POS: return conv1x1_pkg::data_t'(16'h7fff);
      default:     return conv1x1_pkg::data_t'(16'h8000);
    endcase
  endfunction

  task automatic compare_data(input string test_name, input conv1x1_pkg::data_t expected,
                              input conv1x1_pkg::data_t actual);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s: expected %0d (0x%04h), actual %0d (0x%04h)",
               test_name, expected, expected, actual, actual);
    end
  endtask

  task automatic compare_count(input string test_name, input int expected, input int actual);
    check_count++;
    if (actual != expected) begin
      mismatch_count++;
      $display("MISMATCH %s result count: expected %0d, actual %0d",
               test_name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic load_weights(input weight_mode_t mode);
    for (int i = 0; i < PIXEL_CYCLES; i++) begin
      weights[i] = pick_weight(mode, i);
      @(posedge clk);
      #2;
      valid_weight_in = 1'b1;
      weight_in       = weights[i];
    end
    @(posedge clk);
    #2;
    valid_weight_in = 1'b0;
  endtask

  // One pixel at minimum spacing, expected results queued first
  task automatic send_pixel();
    conv1x1_pkg::data_t pixel [CHANNEL_NUM_IN];
    conv1x1_pkg::acc_t  sum;
    int unsigned        r;
    for (int ic = 0; ic < CHANNEL_NUM_IN; ic++) begin
      r = next_random();
      pixel[ic] = conv1x1_pkg::data_t'($signed(r[27:16]));
    end
    for (int oc = 0; oc < CHANNEL_NUM_OUT; oc++) begin
      sum = '0;
      for (int ic = 0; ic < CHANNEL_NUM_IN; ic++) begin
        sum = sum + conv1x1_pkg::acc_t'(pixel[ic]) *
                    conv1x1_pkg::acc_t'(weights[oc * CHANNEL_NUM_IN + ic]);
      end
      expected_q.push_back(conv1x1_pkg::round_sat(sum));
    end
    for (int ic = 0; ic < CHANNEL_NUM_IN; ic++) begin
      @(posedge clk);
      #2;
      valid_in = 1'b1;
      pxl_in   = pixel[ic];
    end
    @(posedge clk);
    #2;
    valid_in = 1'b0;
    repeat (PIXEL_CYCLES - CHANNEL_NUM_IN - 1) @(posedge clk);
  endtask

  task automatic run_test(input int t);
    int start_seen;
    int waited;
    current_name = tests[t].name;
    start_seen   = results_seen;
    load_weights(tests[t].mode);
    for (int p = 0; p < tests[t].pixels; p++) begin
      send_pixel();
    end
    waited = 0;
    while (results_seen - start_seen < tests[t].pixels * CHANNEL_NUM_OUT &&
           waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (waited >= DRAIN_LIMIT) begin
      other_errors++;
      $display("Results of %s still missing %0d cycles after the last pixel",
               tests[t].name, DRAIN_LIMIT);
    end
    // A few idle cycles to catch repeated results
    repeat (4) @(posedge clk);
    compare_count(tests[t].name, tests[t].pixels * CHANNEL_NUM_OUT, results_seen - start_seen);
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (reset && valid_out === 1'b1) begin
      other_errors++;
      $display("valid_out is high while reset is asserted");
    end
    if (!reset && valid_out === 1'b1) begin
      // Draining may only begin once a full FIFO worth is pending
      if (!drain_started) begin
        drain_started = 1'b1;
        if (expected_q.size() < FIFO_DEPTH) begin
          other_errors++;
          $display("First output appeared with only %0d results pending in %s",
                   expected_q.size(), current_name);
        end
      end
      if (expected_q.size() == 0) begin
        other_errors++;
        $display("Output %0d in %s arrived with no result pending", pxl_out, current_name);
      end else begin
        expected_val = expected_q.pop_front();
        compare_data(current_name, expected_val, pxl_out);
      end
      results_seen++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    reset           = 1'b1;
    valid_in        = 1'b0;
    pxl_in          = '0;
    valid_weight_in = 1'b0;
    weight_in       = '0;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             check_count, mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    longint limit_ns;
    int     total_pixels;
    total_pixels = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total_pixels += tests[t].pixels;
    end
    limit_ns = 2 * total_pixels * PIXEL_CYCLES * CLK_PERIOD + 2000;
    #(limit_ns);
    $display("Watchdog expired after %0d ns with tests still running", limit_ns);
    $display("Test failed");
    $finish;
  end

endmodule

// File: compile.f
conv1x1_pkg.sv
conv_loop_buffer.sv
conv_weight_mult.sv
conv_channel_adder.sv
conv_out_align.sv
conv1x1_top.sv
conv1x1_props.sv
tb_conv1x1.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_conv1x1
FILELIST  = compile.f
LOG       = sim.log
PASS_MSG  = Test completed successfully
FAIL_MSG  = Test failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
